// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST)) verif/tb_wb_tasks.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^sim passed$$' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
  import params_pkg::*;
#(
  parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        valid_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  input  logic [31:0] csr_wmask_i,
  input  logic        trap_valid_i,
  input  trap_info_t  trap_i,
  input  logic [31:0] pc_i,
  input  logic [11:0] csr_raddr_i,
  output logic [31:0] csr_rdata_o,
  output logic [31:0] trap_vector_o
);

  logic [31:0] mscratch;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mtval;
  mcause_u     mcause;
  logic        csr_we;

  // keep old bits where the mask is clear
  function automatic logic [31:0] merge(input logic [31:0] old_val,
                                        input logic [31:0] new_val,
                                        input logic [31:0] mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  assign csr_we = valid_i && (csr_addr_i != 12'd0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mscratch   <= 32'd0;
      mtvec      <= MTVEC_RESET;
      mepc       <= 32'd0;
      mtval      <= 32'd0;
      mcause.raw <= 32'd0;
    end else if (valid_i && trap_valid_i) begin
      mepc                <= pc_i;
      mtval               <= trap_i.tval;
      mcause.fields.intr  <= trap_i.cause[31];
      mcause.fields.code  <= trap_i.cause[30:0];
    end else if (csr_we) begin
      unique case (csr_addr_i)
        MSCRATCH: mscratch   <= merge(mscratch, csr_wdata_i, csr_wmask_i);
        MTVEC:    mtvec      <= merge(mtvec, csr_wdata_i, csr_wmask_i);
        MEPC:     mepc       <= merge(mepc, csr_wdata_i, csr_wmask_i);
        MCAUSE:   mcause.raw <= merge(mcause.raw, csr_wdata_i, csr_wmask_i);
        MTVAL:    mtval      <= merge(mtval, csr_wdata_i, csr_wmask_i);
        default: begin
          // writes to unimplemented csrs are dropped
        end
      endcase
    end
  end

  always_comb begin
    unique case (csr_raddr_i)
      MSCRATCH: csr_rdata_o = mscratch;
      MTVEC:    csr_rdata_o = mtvec;
      MEPC:     csr_rdata_o = mepc;
      MCAUSE:   csr_rdata_o = mcause.raw;
      MTVAL:    csr_rdata_o = mtval;
      default:  csr_rdata_o = 32'd0;
    endcase
  end

  // vectored mode only offsets interrupts
  always_comb begin
    trap_vector_o = {mtvec[31:2], 2'b00};
    if (mtvec[1:0] == 2'b01 && mcause.fields.intr) begin
      trap_vector_o = {mtvec[31:2], 2'b00} + {mcause.fields.code[29:0], 2'b00};
    end
  end

  // writeback masks the csr address of a trapped instruction
  a_trap_xor_write: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(trap_valid_i && csr_we)
  ) else $error("csr_file: trap and csr write on the same edge");

endmodule

// ==== design/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg
  import params_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    stall_i,
  input  logic    flush_i,
  input  mem_wb_t mem_wb_d_i,
  output mem_wb_t mem_wb_q_o
);

  mem_wb_t mem_wb_q;

  // flush beats stall, reset looks like a flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      mem_wb_q <= '0;
    end else if (!stall_i) begin
      mem_wb_q <= mem_wb_d_i;
    end
  end

  assign mem_wb_q_o = mem_wb_q;

  // only a real instruction can carry an exception
  a_trap_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_wb_d_i.carried_trap.valid |-> mem_wb_d_i.valid
  ) else $error("mem_wb_reg: trap carried by a bubble");

endmodule

// ==== design/params_pkg.sv ====
package params_pkg;

  // writeback result source, decoded in wb_stage
  typedef enum logic [1:0] {
    RESULT_SEL_ALU_RESULT      = 2'd0,
    RESULT_SEL_MEM_DATA        = 2'd1,
    RESULT_SEL_NEXT_INSTR_ADDR = 2'd2,
    RESULT_SEL_CSR_READ_DATA   = 2'd3
  } result_sel_e;

  // exception carried down the pipe
  typedef struct packed {
    logic        valid;
    logic [31:0] cause;
    logic [31:0] tval;
  } trap_info_t;

  // mcause seen as one word or as interrupt flag plus code
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic        intr;
      logic [30:0] code;
    } fields;
  } mcause_u;

  // instruction leaving the memory stage
  typedef struct packed {
    logic        valid;
    logic        intr;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] pc_plus_4;
    logic [31:0] insn;
    // source operands
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_rdata;
    logic [31:0] rs2_rdata;
    // destination
    logic [4:0]  rd_addr;
    result_sel_e result_sel;
    logic [31:0] alu_csr_result;
    logic [31:0] load_rdata;
    logic [31:0] csr_rdata;
    // csr access
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_wmask;
    logic [31:0] csr_rmask;
    // data memory access
    logic [3:0]  mem_rmask;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
    trap_info_t  carried_trap;
  } mem_wb_t;

  // riscv formal interface retirement record
  typedef struct packed {
    logic        valid;
    logic        intr;
    logic [31:0] pc_rdata;
    logic [31:0] pc_wdata;
    logic [31:0] insn;
    // register file
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
    logic [31:0] rs1_rdata;
    logic [31:0] rs2_rdata;
    logic [31:0] rd_wdata;
    // csr
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_wmask;
    logic [31:0] csr_rdata;
    logic [31:0] csr_rmask;
    // memory
    logic [3:0]  mem_rmask;
    logic [31:0] mem_rdata;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_wdata;
    trap_info_t  trap;
  } rvfi_t;

  // machine csr addresses
  localparam logic [11:0] MSCRATCH = 12'h340;
  localparam logic [11:0] MTVEC    = 12'h305;
  localparam logic [11:0] MEPC     = 12'h341;
  localparam logic [11:0] MCAUSE   = 12'h342;
  localparam logic [11:0] MTVAL    = 12'h343;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile
  import params_pkg::*;
#(
  parameter int NUM_REGS = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        we_i,
  input  logic [4:0]  rd_addr_i,
  input  logic [31:0] rd_wdata_i,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  output logic [31:0] rs1_rdata_o,
  output logic [31:0] rs2_rdata_o
);

  logic [31:0] regs [NUM_REGS];

  // x0 and missing registers read zero
  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    logic [31:0] data;
    data = 32'd0;
    if (addr != 5'd0 && addr < NUM_REGS) begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      regs <= '{default: '0};
    end else if (we_i && rd_addr_i != 5'd0 && rd_addr_i < NUM_REGS) begin
      regs[rd_addr_i] <= rd_wdata_i;
    end
  end

  // no bypass, reads see state after the edge
  assign rs1_rdata_o = read_reg(rs1_addr_i);
  assign rs2_rdata_o = read_reg(rs2_addr_i);

  // decode upstream must respect the rv32e register count
  a_rd_in_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    we_i |-> rd_addr_i < NUM_REGS
  ) else $error("regfile: write to x%0d beyond NUM_REGS", rd_addr_i);

endmodule

// ==== design/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage
  import params_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  mem_wb_t     wb_pipeline_q,
  // csr write address
  output logic [11:0] wb_csr_addr_o,
  // regfile write port
  output logic [4:0]  wb_rd_addr_o,
  output logic [31:0] wb_rd_wdata_o,
  // trap to csr block
  output logic        wb_trap_valid_o,
  // retirement record
  output rvfi_t       rvfi_o
);

  trap_info_t  wb_trap;
  logic        trap_hit;
  logic [4:0]  rd_addr_masked;
  logic [11:0] csr_addr_masked;
  logic [31:0] rd_wdata_sel;
  logic [31:0] rd_wdata_masked;

  assign trap_hit = wb_pipeline_q.carried_trap.valid;
  assign wb_trap  = trap_hit ? wb_pipeline_q.carried_trap : '0;

  // an excepted instruction writes nothing
  assign rd_addr_masked  = trap_hit ? 5'd0 : wb_pipeline_q.rd_addr;
  assign csr_addr_masked = trap_hit ? 12'd0 : wb_pipeline_q.csr_addr;

  always_comb begin
    unique case (wb_pipeline_q.result_sel)
      RESULT_SEL_ALU_RESULT:      rd_wdata_sel = wb_pipeline_q.alu_csr_result;
      RESULT_SEL_MEM_DATA:        rd_wdata_sel = wb_pipeline_q.load_rdata;
      RESULT_SEL_NEXT_INSTR_ADDR: rd_wdata_sel = wb_pipeline_q.pc_plus_4;
      RESULT_SEL_CSR_READ_DATA:   rd_wdata_sel = wb_pipeline_q.csr_rdata;
    endcase
  end

  // x0 target reports zero data
  assign rd_wdata_masked = (rd_addr_masked != 5'd0) ? rd_wdata_sel : 32'd0;

  assign wb_csr_addr_o   = csr_addr_masked;
  assign wb_rd_addr_o    = rd_addr_masked;
  assign wb_rd_wdata_o   = rd_wdata_masked;
  assign wb_trap_valid_o = wb_trap.valid;

  always_comb begin
    // pc and instruction
    rvfi_o.valid     = wb_pipeline_q.valid;
    rvfi_o.intr      = wb_pipeline_q.intr;
    rvfi_o.pc_rdata  = wb_pipeline_q.pc;
    rvfi_o.pc_wdata  = wb_pipeline_q.next_pc;
    rvfi_o.insn      = wb_pipeline_q.insn;
    // registers
    rvfi_o.rs1_addr  = wb_pipeline_q.rs1_addr;
    rvfi_o.rs2_addr  = wb_pipeline_q.rs2_addr;
    rvfi_o.rd_addr   = rd_addr_masked;
    rvfi_o.rs1_rdata = wb_pipeline_q.rs1_rdata;
    rvfi_o.rs2_rdata = wb_pipeline_q.rs2_rdata;
    rvfi_o.rd_wdata  = rd_wdata_masked;
    // csr
    rvfi_o.csr_addr  = csr_addr_masked;
    rvfi_o.csr_wdata = wb_pipeline_q.csr_wdata;
    rvfi_o.csr_wmask = wb_pipeline_q.csr_wmask;
    rvfi_o.csr_rdata = wb_pipeline_q.csr_rdata;
    rvfi_o.csr_rmask = wb_pipeline_q.csr_rmask;
    // memory
    rvfi_o.mem_rmask = wb_pipeline_q.mem_rmask;
    rvfi_o.mem_rdata = wb_pipeline_q.mem_rdata;
    rvfi_o.mem_wmask = wb_pipeline_q.mem_wmask;
    rvfi_o.mem_wdata = wb_pipeline_q.mem_wdata;
    rvfi_o.trap      = wb_trap;
  end

  // upstream computes the link value from the retiring pc
  a_link_matches_pc: assert property (
    @(posedge clk_i) disable iff (rst_i)
    wb_pipeline_q.valid |-> wb_pipeline_q.pc_plus_4 == wb_pipeline_q.pc + 32'd4
  ) else $error("wb_stage: pc_plus_4 does not follow pc");

endmodule

// ==== design/wb_subsys_top.sv ====
`timescale 1ns/1ps

module wb_subsys_top
  import params_pkg::*;
#(
  parameter int          NUM_REGS    = 32,
  parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        stall_i,
  input  logic        flush_i,
  input  mem_wb_t     mem_wb_d_i,
  // debug register reads
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  output logic [31:0] rs1_rdata_o,
  output logic [31:0] rs2_rdata_o,
  // csr read port and trap target
  input  logic [11:0] csr_raddr_i,
  output logic [31:0] csr_rdata_o,
  output logic [31:0] trap_vector_o,
  output logic        trap_valid_o,
  output rvfi_t       rvfi_o
);

  mem_wb_t     mem_wb_q;
  logic [11:0] wb_csr_addr;
  logic [4:0]  wb_rd_addr;
  logic [31:0] wb_rd_wdata;

  mem_wb_reg i_mem_wb_reg (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .mem_wb_d_i (mem_wb_d_i),
    .mem_wb_q_o (mem_wb_q)
  );

  wb_stage i_wb_stage (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wb_pipeline_q   (mem_wb_q),
    .wb_csr_addr_o   (wb_csr_addr),
    .wb_rd_addr_o    (wb_rd_addr),
    .wb_rd_wdata_o   (wb_rd_wdata),
    .wb_trap_valid_o (trap_valid_o),
    .rvfi_o          (rvfi_o)
  );

  // bubbles carry valid low and never write
  regfile #(
    .NUM_REGS (NUM_REGS)
  ) i_regfile (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .we_i        (mem_wb_q.valid),
    .rd_addr_i   (wb_rd_addr),
    .rd_wdata_i  (wb_rd_wdata),
    .rs1_addr_i  (rs1_addr_i),
    .rs2_addr_i  (rs2_addr_i),
    .rs1_rdata_o (rs1_rdata_o),
    .rs2_rdata_o (rs2_rdata_o)
  );

  csr_file #(
    .MTVEC_RESET (MTVEC_RESET)
  ) i_csr_file (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (mem_wb_q.valid),
    .csr_addr_i    (wb_csr_addr),
    .csr_wdata_i   (mem_wb_q.csr_wdata),
    .csr_wmask_i   (mem_wb_q.csr_wmask),
    .trap_valid_i  (trap_valid_o),
    .trap_i        (rvfi_o.trap),
    .pc_i          (mem_wb_q.pc),
    .csr_raddr_i   (csr_raddr_i),
    .csr_rdata_o   (csr_rdata_o),
    .trap_vector_o (trap_vector_o)
  );

endmodule

// ==== list.f ====
+incdir+verif
design/params_pkg.sv
design/mem_wb_reg.sv
design/wb_stage.sv
design/regfile.sv
design/csr_file.sv
design/wb_subsys_top.sv
verif/tb_wb_subsys.sv

// ==== verif/tb_wb_tasks.svh ====
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// advance one edge, then wait out the drive delay
task automatic tick();
  @(posedge clk_i);
  #(DRIVE_DELAY);
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    $display("ERROR t=%0t %s got %08h expected %08h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic report_test(input string name, input int errs_at_start);
  tests_run++;
  if (errors == errs_at_start) begin
    $display("test %s: ok", name);
  end else begin
    tests_failed++;
    $display("test %s: FAIL with %0d mismatches", name, errors - errs_at_start);
  end
endtask

// valid word with random payload, no csr access and no trap
function automatic mem_wb_t make_word(input logic [4:0] rd, input result_sel_e sel);
  mem_wb_t w;
  w = '0;
  w.valid          = 1'b1;
  w.pc             = $urandom() & 32'hffff_fffc;
  w.next_pc        = w.pc + 32'd4;
  w.pc_plus_4      = w.pc + 32'd4;
  w.insn           = $urandom();
  w.rd_addr        = rd;
  w.result_sel     = sel;
  w.alu_csr_result = $urandom();
  w.load_rdata     = $urandom();
  w.csr_rdata      = $urandom();
  return w;
endfunction

// field picked by result_sel, zero for x0 or a trapped word
function automatic logic [31:0] expected_wdata(input mem_wb_t w);
  logic [31:0] data;
  case (w.result_sel)
    RESULT_SEL_MEM_DATA:        data = w.load_rdata;
    RESULT_SEL_NEXT_INSTR_ADDR: data = w.pc_plus_4;
    RESULT_SEL_CSR_READ_DATA:   data = w.csr_rdata;
    default:                    data = w.alu_csr_result;
  endcase
  if (w.rd_addr == 5'd0 || w.carried_trap.valid) begin
    data = 32'd0;
  end
  return data;
endfunction

// bits under the mask take the new value, the rest stay
function automatic logic [31:0] masked_update(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [31:0] mask);
  logic [31:0] result;
  for (int i = 0; i < 32; i++) begin
    if (mask[i]) begin
      result[i] = new_val[i];
    end else begin
      result[i] = old_val[i];
    end
  end
  return result;
endfunction

`endif

// ==== verif/tb_wb_subsys.sv ====
`timescale 1ns/1ps

module tb_wb_subsys
  import params_pkg::*;
();

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DELAY  = 10;
  localparam int          RESET_CYCLES = 16;
  localparam int          NUM_REGS     = 32;
  localparam logic [31:0] MTVEC_RESET  = 32'h0000_0200;
  // edges used by each test, in sequence order
  localparam int          TEST_CYCLES  = 2 + 4 + 2 + 4 + 3 + 4;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 20) * CLK_PERIOD;

  logic        clk_i;
  logic        rst_i;
  logic        stall_i;
  logic        flush_i;
  mem_wb_t     mem_wb_d_i;
  logic [4:0]  rs1_addr_i;
  logic [4:0]  rs2_addr_i;
  logic [31:0] rs1_rdata_o;
  logic [31:0] rs2_rdata_o;
  logic [11:0] csr_raddr_i;
  logic [31:0] csr_rdata_o;
  logic [31:0] trap_vector_o;
  logic        trap_valid_o;
  rvfi_t       rvfi_o;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] saved_x5;

  `include "tb_wb_tasks.svh"

  wb_subsys_top #(
    .NUM_REGS    (NUM_REGS),
    .MTVEC_RESET (MTVEC_RESET)
  ) i_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: test sequence still running after %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

  task automatic reg_write_readback();
    int start;
    mem_wb_t w;
    start = errors;
    w = make_word(5'd5, RESULT_SEL_ALU_RESULT);
    mem_wb_d_i = w;
    rs1_addr_i = 5'd5;
    tick();
    check_value("rvfi.valid", 32'(rvfi_o.valid), 32'd1);
    check_value("rvfi.rd_addr", 32'(rvfi_o.rd_addr), 32'd5);
    check_value("rvfi.rd_wdata", rvfi_o.rd_wdata, w.alu_csr_result);
    check_value("rvfi.pc_rdata", rvfi_o.pc_rdata, w.pc);
    mem_wb_d_i = '0;
    tick();
    check_value("rs1_rdata x5", rs1_rdata_o, w.alu_csr_result);
    saved_x5 = w.alu_csr_result;
    report_test("reg_write_readback", start);
  endtask

  task automatic result_select();
    int start;
    mem_wb_t w;
    start = errors;
    for (int s = 0; s < 4; s++) begin
      w = make_word(5'(10 + s), result_sel_e'(s));
      mem_wb_d_i = w;
      tick();
      check_value($sformatf("rvfi.rd_wdata sel %0d", s), rvfi_o.rd_wdata, expected_wdata(w));
    end
    mem_wb_d_i = '0;
    report_test("result_select", start);
  endtask

  task automatic x0_write();
    int start;
    mem_wb_t w;
    start = errors;
    w = make_word(5'd0, RESULT_SEL_ALU_RESULT);
    w.alu_csr_result = $urandom() | 32'h1;
    mem_wb_d_i = w;
    rs1_addr_i = 5'd0;
    tick();
    check_value("rvfi.rd_wdata", rvfi_o.rd_wdata, 32'd0);
    mem_wb_d_i = '0;
    tick();
    check_value("rs1_rdata x0", rs1_rdata_o, 32'd0);
    report_test("x0_write", start);
  endtask

  task automatic trap_capture();
    int start;
    mem_wb_t w;
    start = errors;
    w = make_word(5'd5, RESULT_SEL_ALU_RESULT);
    w.csr_addr = MSCRATCH;
    w.csr_wdata = $urandom();
    w.csr_wmask = 32'hffff_ffff;
    w.carried_trap.valid = 1'b1;
    w.carried_trap.cause = $urandom() & 32'h0000_001f;
    w.carried_trap.tval = $urandom();
    mem_wb_d_i = w;
    rs1_addr_i = 5'd5;
    csr_raddr_i = MEPC;
    tick();
    check_value("trap_valid_o", 32'(trap_valid_o), 32'd1);
    check_value("rvfi.rd_addr", 32'(rvfi_o.rd_addr), 32'd0);
    check_value("rvfi.csr_addr", 32'(rvfi_o.csr_addr), 32'd0);
    check_value("rvfi.rd_wdata", rvfi_o.rd_wdata, expected_wdata(w));
    check_value("rvfi.trap.cause", rvfi_o.trap.cause, w.carried_trap.cause);
    mem_wb_d_i = '0;
    tick();
    check_value("rs1_rdata x5", rs1_rdata_o, saved_x5);
    check_value("mepc", csr_rdata_o, w.pc);
    csr_raddr_i = MCAUSE;
    tick();
    check_value("mcause", csr_rdata_o, w.carried_trap.cause);
    csr_raddr_i = MTVAL;
    tick();
    check_value("mtval", csr_rdata_o, w.carried_trap.tval);
    check_value("trap_vector_o", trap_vector_o, MTVEC_RESET);
    report_test("trap_capture", start);
  endtask

  task automatic masked_csr_write();
    int start;
    mem_wb_t w;
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] mask;
    start = errors;
    first = $urandom();
    second = $urandom();
    mask = $urandom();
    w = make_word(5'd0, RESULT_SEL_CSR_READ_DATA);
    w.csr_addr = MSCRATCH;
    w.csr_wdata = first;
    w.csr_wmask = 32'hffff_ffff;
    mem_wb_d_i = w;
    csr_raddr_i = MSCRATCH;
    tick();
    w.csr_wdata = second;
    w.csr_wmask = mask;
    mem_wb_d_i = w;
    tick();
    check_value("mscratch full write", csr_rdata_o, first);
    mem_wb_d_i = '0;
    tick();
    check_value("mscratch masked write", csr_rdata_o, masked_update(first, second, mask));
    report_test("masked_csr_write", start);
  endtask

  task automatic stall_and_flush();
    int start;
    mem_wb_t w_old;
    start = errors;
    w_old = make_word(5'd20, RESULT_SEL_ALU_RESULT);
    mem_wb_d_i = w_old;
    rs1_addr_i = 5'd22;
    rs2_addr_i = 5'd21;
    tick();
    stall_i = 1'b1;
    mem_wb_d_i = make_word(5'd21, RESULT_SEL_ALU_RESULT);
    tick();
    check_value("rvfi.pc_rdata stalled", rvfi_o.pc_rdata, w_old.pc);
    check_value("rvfi.rd_addr stalled", 32'(rvfi_o.rd_addr), 32'd20);
    check_value("rvfi.rd_wdata stalled", rvfi_o.rd_wdata, w_old.alu_csr_result);
    stall_i = 1'b0;
    flush_i = 1'b1;
    mem_wb_d_i = make_word(5'd22, RESULT_SEL_ALU_RESULT);
    tick();
    check_value("rvfi.valid flushed", 32'(rvfi_o.valid), 32'd0);
    flush_i = 1'b0;
    mem_wb_d_i = '0;
    tick();
    check_value("rs1_rdata x22", rs1_rdata_o, 32'd0);
    check_value("rs2_rdata x21", rs2_rdata_o, 32'd0);
    report_test("stall_and_flush", start);
  endtask

  initial begin
    void'($urandom(54));
    clk_i = 1'b0;
    rst_i = 1'b1;
    stall_i = 1'b0;
    flush_i = 1'b0;
    mem_wb_d_i = '0;
    rs1_addr_i = 5'd0;
    rs2_addr_i = 5'd0;
    csr_raddr_i = 12'd0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_i = 1'b0;
    reg_write_readback();
    result_select();
    x0_write();
    trap_capture();
    masked_csr_write();
    stall_and_flush();
    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
